// ==== rtl/busPkg.sv ====
package busPkg;

  // Fabric size
  localparam int NumMasters = 4;
  localparam int NumTargets = 4;

  // Bus widths
  localparam int AddrWidth  = 32;
  localparam int DataWidth  = 16;
  localparam int CountWidth = 9;

  typedef logic [AddrWidth-1:0]  addrT;
  typedef logic [DataWidth-1:0]  dataT;
  typedef logic [CountWidth-1:0] countT;

  typedef enum logic {
    ArbIdle,
    ArbBusy
  } arbStateT;

  // Inclusive address range of each target
  localparam addrT TargetBase [NumTargets] = '{
    32'hffff8ddc,
    32'hffff7015,
    32'hffff58ce,
    32'hffff3ca5
  };

  localparam addrT TargetLimit [NumTargets] = '{
    32'hffff8edc,
    32'hffff7085,
    32'hffff58df,
    32'hffff3d61
  };

  // Transfers per window each master may take before it counts as satisfied
  localparam countT DefaultQuota [NumMasters] = '{
    9'd105,
    9'd30,
    9'd96,
    9'd30
  };

  // Completed transfers before all counts clear
  localparam countT DefaultWindowLen = 9'd500;

endpackage

// ==== rtl/quotaArbiter.sv ====
`timescale 1ns/100ps

module quotaArbiter #(
  parameter busPkg::countT WindowLen = busPkg::DefaultWindowLen,
  parameter busPkg::countT Quota [busPkg::NumMasters] = busPkg::DefaultQuota
) (
  input  logic                          sysClk,
  input  logic                          rstN,
  input  logic [busPkg::NumMasters-1:0] request,
  input  logic                          transferDone,
  output logic [busPkg::NumMasters-1:0] grant
);

  busPkg::arbStateT state;

  // Completed transfers per master in the current window
  busPkg::countT xferCount [busPkg::NumMasters];
  busPkg::countT windowCount;

  logic [busPkg::NumMasters-1:0] belowQuota;
  logic [busPkg::NumMasters-1:0] hungry;
  logic [busPkg::NumMasters-1:0] eligible;
  logic [busPkg::NumMasters-1:0] winner;
  logic                          windowFull;

  always_comb begin
    for (int m = 0; m < busPkg::NumMasters; m++) begin
      belowQuota[m] = xferCount[m] < Quota[m];
    end
  end

  assign hungry = request & belowQuota;

  // Unsatisfied requesters first, otherwise fall back to any requester
  assign eligible = (|hungry) ? hungry : request;

  // Lowest index wins
  assign winner = eligible & -eligible;

  assign windowFull = windowCount == WindowLen;

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      state       <= busPkg::ArbIdle;
      grant       <= '0;
      windowCount <= '0;
      for (int m = 0; m < busPkg::NumMasters; m++) begin
        xferCount[m] <= '0;
      end
    end else begin
      case (state)
        busPkg::ArbIdle: begin
          if (windowFull) begin
            // New window, nobody granted on this edge
            windowCount <= '0;
            for (int m = 0; m < busPkg::NumMasters; m++) begin
              xferCount[m] <= '0;
            end
          end else if (|request) begin
            grant <= winner;
            state <= busPkg::ArbBusy;
          end
        end

        busPkg::ArbBusy: begin
          if (transferDone) begin
            // Credit the owner and release the bus
            for (int m = 0; m < busPkg::NumMasters; m++) begin
              if (grant[m]) begin
                xferCount[m] <= xferCount[m] + 1'b1;
              end
            end
            windowCount <= windowCount + 1'b1;
            grant       <= '0;
            state       <= busPkg::ArbIdle;
          end
        end
      endcase
    end
  end

endmodule

// ==== rtl/targetRouter.sv ====
`timescale 1ns/100ps

module targetRouter (
  input  logic                          sysClk,
  input  logic                          rstN,
  input  logic [busPkg::NumMasters-1:0] grant,
  input  busPkg::addrT                  masterAddr [busPkg::NumMasters],
  input  busPkg::dataT                  masterWdata [busPkg::NumMasters],
  output busPkg::dataT                  masterRdata [busPkg::NumMasters],
  output logic [busPkg::NumTargets-1:0] targetActive,
  output busPkg::addrT                  targetAddr [busPkg::NumTargets],
  output busPkg::dataT                  targetWdata [busPkg::NumTargets],
  input  busPkg::dataT                  targetRdata [busPkg::NumTargets],
  input  logic [busPkg::NumTargets-1:0] targetLast,
  output logic                          transferDone
);

  localparam int MasterIdxW = $clog2(busPkg::NumMasters);
  localparam int TargetIdxW = $clog2(busPkg::NumTargets);

  logic [MasterIdxW-1:0]         masterSel;
  logic [TargetIdxW-1:0]         targetSel;
  logic [busPkg::NumTargets-1:0] targetHit;
  busPkg::addrT                  selAddr;
  logic                          anyGrant;
  logic                          routeBusy;

  assign anyGrant = |grant;

  // Grant is one-hot, so this just turns it into an index
  always_comb begin
    masterSel = '0;
    for (int m = 0; m < busPkg::NumMasters; m++) begin
      if (grant[m]) begin
        masterSel = MasterIdxW'(m);
      end
    end
  end

  assign selAddr = masterAddr[masterSel];

  // Address map decode
  always_comb begin
    targetHit = '0;
    targetSel = '0;
    for (int t = 0; t < busPkg::NumTargets; t++) begin
      if (selAddr >= busPkg::TargetBase[t] && selAddr <= busPkg::TargetLimit[t]) begin
        targetHit[t] = 1'b1;
        targetSel    = TargetIdxW'(t);
      end
    end
  end

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      targetActive <= '0;
      routeBusy    <= 1'b0;
      transferDone <= 1'b0;
    end else begin
      // Last from an idle target has no effect
      transferDone <= |(targetLast & targetActive);
      targetActive <= targetActive & ~targetLast;
      if (!anyGrant) begin
        routeBusy <= 1'b0;
      end else if (!routeBusy && |targetHit) begin
        // One activation per grant, grant outlives the target by a cycle
        targetActive <= targetHit;
        routeBusy    <= 1'b1;
      end
    end
  end

  always_ff @(posedge sysClk) begin
    if (anyGrant) begin
      for (int t = 0; t < busPkg::NumTargets; t++) begin
        if (targetHit[t]) begin
          targetAddr[t]  <= selAddr;
          targetWdata[t] <= masterWdata[masterSel];
        end
      end
      if (|targetHit) begin
        masterRdata[masterSel] <= targetRdata[targetSel];
      end
    end
  end

endmodule

// ==== rtl/busFabric.sv ====
`timescale 1ns/100ps

module busFabric #(
  parameter busPkg::countT WindowLen = busPkg::DefaultWindowLen,
  parameter busPkg::countT Quota [busPkg::NumMasters] = busPkg::DefaultQuota
) (
  input  logic                          sysClk,
  input  logic                          rstN,

  // Master side
  input  logic [busPkg::NumMasters-1:0] request,
  input  busPkg::addrT                  masterAddr [busPkg::NumMasters],
  input  busPkg::dataT                  masterWdata [busPkg::NumMasters],
  output logic [busPkg::NumMasters-1:0] grant,
  output busPkg::dataT                  masterRdata [busPkg::NumMasters],

  // Target side
  output logic [busPkg::NumTargets-1:0] targetActive,
  output busPkg::addrT                  targetAddr [busPkg::NumTargets],
  output busPkg::dataT                  targetWdata [busPkg::NumTargets],
  input  busPkg::dataT                  targetRdata [busPkg::NumTargets],
  input  logic [busPkg::NumTargets-1:0] targetLast
);

  // Router tells the arbiter the owner's transfer has ended
  logic transferDone;

  quotaArbiter #(
    .WindowLen (WindowLen),
    .Quota     (Quota)
  ) quotaArbiter_i (
    .sysClk       (sysClk),
    .rstN         (rstN),
    .request      (request),
    .transferDone (transferDone),
    .grant        (grant)
  );

  targetRouter targetRouter_i (
    .sysClk       (sysClk),
    .rstN         (rstN),
    .grant        (grant),
    .masterAddr   (masterAddr),
    .masterWdata  (masterWdata),
    .masterRdata  (masterRdata),
    .targetActive (targetActive),
    .targetAddr   (targetAddr),
    .targetWdata  (targetWdata),
    .targetRdata  (targetRdata),
    .targetLast   (targetLast),
    .transferDone (transferDone)
  );

endmodule

// ==== bench/busFabric_sva.sv ====
`timescale 1ns/100ps

module busFabricSva (
  input logic                          sysClk,
  input logic                          rstN,
  input logic [busPkg::NumMasters-1:0] grant,
  input logic [busPkg::NumTargets-1:0] targetActive
);

  // Number of assertion failures seen so far
  int failCount = 0;

  // Single bus owner
  oneGrant: assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(grant))
    else begin
      $error("more than one grant high: %b", grant);
      failCount++;
    end

  oneTarget: assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(targetActive))
    else begin
      $error("more than one target active: %b", targetActive);
      failCount++;
    end

  // A reset edge leaves every grant low
  noGrantInReset: assert property (@(posedge sysClk) !rstN |=> grant == '0)
    else begin
      $error("grant high during reset: %b", grant);
      failCount++;
    end

endmodule

// ==== bench/busFabricTb.sv ====
`timescale 1ns/100ps

module busFabricTb;

  localparam int Timeout = 20;
  localparam busPkg::countT TbQuota [busPkg::NumMasters] = '{9'd2, 9'd2, 9'd2, 9'd2};

  logic                          sysClk = 1'b0;
  logic                          rstN;
  logic [busPkg::NumMasters-1:0] request;
  busPkg::addrT                  masterAddr [busPkg::NumMasters];
  busPkg::dataT                  masterWdata [busPkg::NumMasters];
  logic [busPkg::NumMasters-1:0] grant;
  busPkg::dataT                  masterRdata [busPkg::NumMasters];
  logic [busPkg::NumTargets-1:0] targetActive;
  busPkg::addrT                  targetAddr [busPkg::NumTargets];
  busPkg::dataT                  targetWdata [busPkg::NumTargets];
  busPkg::dataT                  targetRdata [busPkg::NumTargets];
  logic [busPkg::NumTargets-1:0] targetLast = '0;

  // Target model state
  logic [busPkg::NumTargets-1:0] strayLast;
  logic [busPkg::NumTargets-1:0] modelArmed;
  int                            lastDelay [busPkg::NumTargets];
  logic                          modelHold;

  int           seed = 53;
  int           errors = 0;
  int           checks = 0;
  busPkg::dataT rdBase;

  always #4 sysClk = ~sysClk;

  busFabric #(
    .WindowLen (9'd6),
    .Quota     (TbQuota)
  ) busFabric_i (.*);

  bind busFabric busFabricSva busFabricSva_i (
    .sysClk       (sysClk),
    .rstN         (rstN),
    .grant        (grant),
    .targetActive (targetActive)
  );

  // Each target answers with last 1 to 4 cycles after it goes active
  always @(posedge sysClk) begin
    int pick;
    for (int t = 0; t < busPkg::NumTargets; t++) begin
      targetLast[t] <= strayLast[t];
      if (!rstN || !targetActive[t]) begin
        modelArmed[t] <= 1'b1;
        lastDelay[t]  <= -1;
      end else if (!modelHold) begin
        if (modelArmed[t]) begin
          pick = $unsigned($random(seed)) % 4;
          modelArmed[t] <= 1'b0;
          targetLast[t] <= pick == 0;
          lastDelay[t]  <= pick - 1;
        end else if (lastDelay[t] == 0) begin
          targetLast[t] <= 1'b1;
          lastDelay[t]  <= -1;
        end else if (lastDelay[t] > 0) begin
          lastDelay[t] <= lastDelay[t] - 1;
        end
      end
    end
  end

  function automatic busPkg::addrT pickAddr(input int t);
    busPkg::addrT span;
    span = busPkg::TargetLimit[t] - busPkg::TargetBase[t] + 1;
    return busPkg::TargetBase[t] + ($unsigned($random(seed)) % span);
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
    errors++;
    $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
  endtask

  task automatic timeoutAbort(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic expectIdle();
    checks += 2;
    if (grant !== '0) reportMismatch("grant", 32'(grant), 32'd0);
    if (targetActive !== '0) reportMismatch("targetActive", 32'(targetActive), 32'd0);
  endtask

  task automatic resetDut();
    @(posedge sysClk);
    rstN    <= 1'b0;
    request <= '0;
    repeat (2) begin
      @(negedge sysClk);
      expectIdle();
    end
    @(posedge sysClk);
    rstN <= 1'b1;
    @(negedge sysClk);
    expectIdle();
  endtask

  // Call right after a rising edge
  task automatic startRequest(input int m, input int t);
    request[m]     <= 1'b1;
    masterAddr[m]  <= pickAddr(t);
    masterWdata[m] <= busPkg::dataT'($random(seed));
  endtask

  task automatic waitGrant(input int m);
    int                            waited;
    logic [busPkg::NumMasters-1:0] expGrant;
    waited      = 0;
    expGrant    = '0;
    expGrant[m] = 1'b1;
    while (grant == '0 && waited < Timeout) begin
      @(negedge sysClk);
      waited++;
    end
    if (grant == '0) begin
      timeoutAbort("no master was granted");
    end else begin
      checks++;
      if (grant !== expGrant) begin
        reportMismatch("grant", 32'(grant), 32'(expGrant));
      end
    end
  endtask

  task automatic finishTransfer(input int m);
    int waited;
    waited = 0;
    while (!(|(targetLast & targetActive)) && waited < Timeout) begin
      @(negedge sysClk);
      waited++;
    end
    if (!(|(targetLast & targetActive))) begin
      timeoutAbort("active target never pulsed last");
    end else begin
      // Arbiter is still busy on this edge, so dropping request cannot retrigger it
      @(posedge sysClk);
      request[m] <= 1'b0;
      @(negedge sysClk);
      checks++;
      if (targetActive !== '0) reportMismatch("targetActive", 32'(targetActive), 32'd0);
      @(negedge sysClk);
      checks++;
      if (grant !== '0) reportMismatch("grant", 32'(grant), 32'd0);
    end
  endtask

  task automatic doTransfer(input int m, input int t);
    @(posedge sysClk);
    startRequest(m, t);
    waitGrant(m);
    finishTransfer(m);
  endtask

  task automatic resetTest();
    resetDut();
    repeat (2) begin
      @(negedge sysClk);
      expectIdle();
    end
  endtask

  task automatic singleTransferTest();
    busPkg::dataT expRdata;
    resetDut();
    expRdata = rdBase + busPkg::dataT'(2);
    @(posedge sysClk);
    startRequest(1, 2);
    @(negedge sysClk);
    checks++;
    if (grant !== 4'b0000) reportMismatch("grant", 32'(grant), 32'h0);
    @(negedge sysClk);
    checks++;
    if (grant !== 4'b0010) reportMismatch("grant", 32'(grant), 32'h2);
    @(negedge sysClk);
    checks += 4;
    if (targetActive !== 4'b0100) reportMismatch("targetActive", 32'(targetActive), 32'h4);
    if (targetAddr[2] !== masterAddr[1]) begin
      reportMismatch("targetAddr[2]", targetAddr[2], masterAddr[1]);
    end
    if (targetWdata[2] !== masterWdata[1]) begin
      reportMismatch("targetWdata[2]", 32'(targetWdata[2]), 32'(masterWdata[1]));
    end
    if (masterRdata[1] !== expRdata) begin
      reportMismatch("masterRdata[1]", 32'(masterRdata[1]), 32'(expRdata));
    end
    finishTransfer(1);
  endtask

  task automatic rankTest();
    resetDut();
    @(posedge sysClk);
    startRequest(2, 0);
    startRequest(3, 1);
    waitGrant(2);
    finishTransfer(2);
    waitGrant(3);
    finishTransfer(3);
  endtask

  task automatic quotaTest();
    resetDut();
    repeat (2) doTransfer(0, 3);
    @(posedge sysClk);
    startRequest(0, 0);
    startRequest(1, 1);
    // Master 0 has used up its quota
    waitGrant(1);
    finishTransfer(1);
    waitGrant(0);
    finishTransfer(0);
  endtask

  task automatic windowTest();
    resetDut();
    for (int m = 0; m < busPkg::NumMasters; m++) begin
      if (m != 1) begin
        repeat (2) doTransfer(m, m);
      end
    end
    @(posedge sysClk);
    startRequest(0, 1);
    startRequest(1, 2);
    // Without the window clear master 1 would win here
    waitGrant(0);
    finishTransfer(0);
    waitGrant(1);
    finishTransfer(1);
  endtask

  task automatic strayLastTest();
    resetDut();
    @(posedge sysClk);
    modelHold <= 1'b1;
    startRequest(0, 0);
    waitGrant(0);
    @(negedge sysClk);
    checks++;
    if (targetActive !== 4'b0001) reportMismatch("targetActive", 32'(targetActive), 32'h1);
    @(posedge sysClk);
    strayLast[3] <= 1'b1;
    @(posedge sysClk);
    strayLast[3] <= 1'b0;
    repeat (3) begin
      @(negedge sysClk);
      checks += 2;
      if (grant !== 4'b0001) reportMismatch("grant", 32'(grant), 32'h1);
      if (targetActive !== 4'b0001) reportMismatch("targetActive", 32'(targetActive), 32'h1);
    end
    @(posedge sysClk);
    modelHold <= 1'b0;
    finishTransfer(0);
  endtask

  initial begin
    rstN      <= 1'b0;
    request   <= '0;
    modelHold <= 1'b0;
    strayLast <= '0;
    rdBase = busPkg::dataT'($random(seed));
    for (int m = 0; m < busPkg::NumMasters; m++) begin
      masterAddr[m]  <= '0;
      masterWdata[m] <= '0;
    end
    for (int t = 0; t < busPkg::NumTargets; t++) begin
      targetRdata[t] <= rdBase + busPkg::dataT'(t);
    end

    resetTest();
    singleTransferTest();
    rankTest();
    quotaTest();
    windowTest();
    strayLastTest();

    errors += busFabric_i.busFabricSva_i.failCount;
    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/busPkg.sv
rtl/quotaArbiter.sv
rtl/targetRouter.sv
rtl/busFabric.sv
bench/busFabric_sva.sv
bench/busFabricTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the bus fabric testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module busFabricTb -f sim.f -o busFabricSim \
  || { echo "Verilator build failed"; exit 1; }

simOut=$(./obj_dir/busFabricSim)
echo "$simOut"
echo "$simOut" | grep -q "^TEST PASS$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
